// File: Makefile
# Verilator flow for the TV box testbench
# Override any variable on the command line, e.g. make sim JOBS=8

VERILATOR  ?= verilator
FILELIST   ?= tvBox.f
TB_TOP     ?= tvBox_tb
RTL_TOP    ?= tvBox
BUILD_DIR  ?= obj_dir
JOBS       ?= 4
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal -j $(JOBS)

.PHONY: all lint lint-rtl build sim clean

all: sim

# Whole project, testbench included
lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TB_TOP)

# Design top level alone
lint-rtl:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

# Exit status of the simulation is the result
sim: build
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: hw/blobMarker.sv
`timescale 1ns/1ps
`include "tvBox_params.svh"

// Marks blobs where a full 3x3 window of set bits is found
module blobMarker
  import videoPkg::*;
#(
  parameter int lineWidth = `LINE_WIDTH   // Pixels per line
)
(
  input  logic      OSC_50,
  input  logic      KEY,        // Async reset, active low
  input  logic      setBit,
  input  logic      setValid,
  output rgbPixel_t pixelOut,
  output logic      outValid
);

  // ------------------------------
  // Line delays and window rows
  // ------------------------------
  // lineDelay[0] is one line back, lineDelay[1] two lines back
  logic [1:0][lineWidth-1:0] lineDelay;

  logic        tapUp1;      // Same column, line above
  logic        tapUp2;      // Same column, two lines above
  logic [2:0]  rowCur;      // Bit 0 newest
  logic [2:0]  rowUp1;
  logic [2:0]  rowUp2;
  markWindow_t nextWindow;  // Window after this shift
  rgbPixel_t   nextColour;

  assign tapUp1 = lineDelay[0][lineWidth-1];
  assign tapUp2 = lineDelay[1][lineWidth-1];

  // Updated window, shifted by one pixel
  assign nextWindow = {rowUp2[1:0], tapUp2,
                       rowUp1[1:0], tapUp1,
                       rowCur[1:0], setBit};

  always_ff @(posedge OSC_50 or negedge KEY)
  begin
    if (!KEY)
    begin
      lineDelay <= '0;
      rowCur    <= '0;
      rowUp1    <= '0;
      rowUp2    <= '0;
    end
    else if (setValid)                      // Gaps hold everything
    begin
      lineDelay[0] <= {lineDelay[0][lineWidth-2:0], setBit};
      lineDelay[1] <= {lineDelay[1][lineWidth-2:0], tapUp1};
      rowCur       <= nextWindow[2:0];
      rowUp1       <= nextWindow[5:3];
      rowUp2       <= nextWindow[8:6];
    end
  end

  // ------------------------------
  // Output colouring
  // ------------------------------
  always_comb
  begin
    if (nextWindow == windowFull)
      nextColour = pixelRed;                // Whole window set
    else if (setBit)
      nextColour = pixelWhite;              // Current pixel only
    else
      nextColour = pixelBlack;
  end

  always_ff @(posedge OSC_50 or negedge KEY)
  begin
    if (!KEY)
    begin
      pixelOut <= pixelBlack;
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= setValid;                 // Second pipeline stage
      if (setValid)
        pixelOut <= nextColour;
    end
  end

endmodule

// File: hw/lumaThreshold.sv
`timescale 1ns/1ps
`include "tvBox_params.svh"

// Gray conversion and threshold compare, one register stage
module lumaThreshold
  import videoPkg::*;
(
  input  logic                    OSC_50,
  input  logic                    KEY,        // Async reset, active low
  input  rgbPixel_t               pixelIn,
  input  logic                    pixelValid,
  input  logic [`COLOR_WIDTH-1:0] threshold,  // From DPDT_SW[17:8]
  output logic                    setBit,
  output logic                    setValid
);

  logic [`COLOR_WIDTH-1:0] gray;
  logic                    aboveThreshold;

  // ------------------------------
  // Shift-weighted gray, r/4 + g/2 + b/8
  // ------------------------------
  // Max 255 + 511 + 127 = 893, fits in 10 bits
  assign gray = (pixelIn.red >> 2) + (pixelIn.green >> 1) + (pixelIn.blue >> 3);

  assign aboveThreshold = (gray > threshold);  // Strictly greater

  // Strobe follows pixelValid by one cycle
  always_ff @(posedge OSC_50 or negedge KEY)
  begin
    if (!KEY)
      setValid <= 1'b0;
    else
      setValid <= pixelValid;
  end

  // Result captured only with a valid pixel
  always_ff @(posedge OSC_50)
  begin
    if (pixelValid)
      setBit <= aboveThreshold;
  end

endmodule

// File: hw/padAutoPress.sv
`timescale 1ns/1ps
`include "tvBox_params.svh"

// Periodic A press and switch mapping for the pad header
module padAutoPress
  import panelPkg::*;
#(
  parameter int pressPeriod = `PRESS_PERIOD,  // Cycles per period
  parameter int pressStart  = `PRESS_START    // First pressed cycle
)
(
  input  logic        OSC_50,
  input  logic        KEY,          // Async reset, active low
  input  logic [1:0]  DPDT_SW,      // Low two switches
  output padButtons_t padButtons
);

  localparam int periodWidth = $clog2(pressPeriod);

  logic [periodWidth-1:0] periodCount;
  logic                   pressA;

  // ------------------------------
  // Period counter and A press
  // ------------------------------
  always_ff @(posedge OSC_50 or negedge KEY)
  begin
    if (!KEY)
    begin
      periodCount <= '0;
      pressA      <= 1'b0;                  // Released after reset
    end
    else if (periodCount == periodWidth'(pressPeriod - 1))
    begin
      periodCount <= '0;
      pressA      <= 1'b0;                  // End of period, release
    end
    else
    begin
      periodCount <= periodCount + 1'b1;
      if (periodCount == periodWidth'(pressStart - 1))
        pressA <= 1'b1;                     // Press from pressStart on
    end
  end

  // Start releases b and right
  assign padButtons = '{start: DPDT_SW[0], select: DPDT_SW[1], a: pressA,
                        b: ~DPDT_SW[0], left: 1'b1, right: ~DPDT_SW[0],
                        up: 1'b0, down: 1'b0};

endmodule

// File: hw/panelPkg.sv
// ------------------------------
// Front panel types
// ------------------------------
package panelPkg;

  // Seven-segment pattern, active low
  // Bit 0 is segment a, bit 6 is segment g
  typedef logic [6:0] sevenSeg_t;

  // One decimal digit, 0..9
  typedef logic [3:0] bcdDigit_t;

  // Pad header buttons, active high
  // Start sits in the top bit
  typedef struct packed {
    logic start;
    logic select;
    logic a;
    logic b;
    logic left;
    logic right;
    logic up;
    logic down;
  } padButtons_t;

  // Largest value a digit may hold before it carries
  localparam bcdDigit_t digitMax = 4'd9;

endpackage

// File: hw/tvBox.sv
`timescale 1ns/1ps
`include "tvBox_params.svh"

// TV box top level, four independent peers
module tvBox
  import videoPkg::*, panelPkg::*;
#(
  parameter int lineWidth      = `LINE_WIDTH,
  parameter int ticksPerSecond = `TICKS_PER_SECOND,
  parameter int pressPeriod    = `PRESS_PERIOD,
  parameter int pressStart     = `PRESS_START
)
(
  input  logic        OSC_50,      // 50 MHz
  input  logic        KEY,         // Async reset, active low
  input  logic [17:0] DPDT_SW,
  input  rgbPixel_t   pixelIn,     // RGB stream in raster order
  input  logic        pixelValid,
  output rgbPixel_t   pixelOut,    // Marked stream, two cycles later
  output logic        outValid,
  output sevenSeg_t   HEX0,
  output sevenSeg_t   HEX1,
  output sevenSeg_t   HEX2,
  output sevenSeg_t   HEX3,
  output sevenSeg_t   HEX4,
  output sevenSeg_t   HEX5,
  output sevenSeg_t   HEX6,
  output sevenSeg_t   HEX7,
  output padButtons_t padButtons
);

  logic setBit;     // Thresholded pixel
  logic setValid;

  // ------------------------------
  // Pixel path
  // ------------------------------
  lumaThreshold i_lumaThreshold (
    .OSC_50     (OSC_50),
    .KEY        (KEY),
    .pixelIn    (pixelIn),
    .pixelValid (pixelValid),
    .threshold  (DPDT_SW[17:8]),
    .setBit     (setBit),
    .setValid   (setValid)
  );

  blobMarker #(.lineWidth(lineWidth)) i_blobMarker (
    .OSC_50   (OSC_50),
    .KEY      (KEY),
    .setBit   (setBit),
    .setValid (setValid),
    .pixelOut (pixelOut),
    .outValid (outValid)
  );

  // ------------------------------
  // Front panel
  // ------------------------------
  uptimeCounter #(.ticksPerSecond(ticksPerSecond)) i_uptimeCounter (
    .OSC_50 (OSC_50),
    .KEY    (KEY),
    .HEX0   (HEX0),
    .HEX1   (HEX1),
    .HEX2   (HEX2),
    .HEX3   (HEX3)
  );

  // Upper four digits unused
  assign HEX4 = `SEG_BLANK;
  assign HEX5 = `SEG_BLANK;
  assign HEX6 = `SEG_BLANK;
  assign HEX7 = `SEG_BLANK;

  padAutoPress #(.pressPeriod(pressPeriod), .pressStart(pressStart)) i_padAutoPress (
    .OSC_50     (OSC_50),
    .KEY        (KEY),
    .DPDT_SW    (DPDT_SW[1:0]),
    .padButtons (padButtons)
  );

endmodule

// File: hw/uptimeCounter.sv
`timescale 1ns/1ps
`include "tvBox_params.svh"

// Seconds since reset on HEX0..HEX3, decimal
module uptimeCounter
  import panelPkg::*;
#(
  parameter int ticksPerSecond = `TICKS_PER_SECOND
)
(
  input  logic      OSC_50,
  input  logic      KEY,     // Async reset, active low
  output sevenSeg_t HEX0,    // Ones
  output sevenSeg_t HEX1,    // Tens
  output sevenSeg_t HEX2,    // Hundreds
  output sevenSeg_t HEX3     // Thousands
);

  localparam int tickWidth = $clog2(ticksPerSecond);

  logic [tickWidth-1:0]               tickCount;
  logic                               secondTick;
  bcdDigit_t [`DIGIT_COUNT-1:0]       digits;      // Index 0 is ones
  bcdDigit_t [`DIGIT_COUNT-1:0]       nextDigits;

  // Active-low pattern for one digit
  function automatic sevenSeg_t segDecode(input bcdDigit_t digit);
    case (digit)
      4'd0:    return `SEG_0;
      4'd1:    return `SEG_1;
      4'd2:    return `SEG_2;
      4'd3:    return `SEG_3;
      4'd4:    return `SEG_4;
      4'd5:    return `SEG_5;
      4'd6:    return `SEG_6;
      4'd7:    return `SEG_7;
      4'd8:    return `SEG_8;
      4'd9:    return `SEG_9;
      default: return `SEG_BLANK;
    endcase
  endfunction

  // ------------------------------
  // Second tick divider
  // ------------------------------
  assign secondTick = (tickCount == tickWidth'(ticksPerSecond - 1));

  // Decimal carry chain, 9999 wraps to 0000
  always_comb
  begin
    logic carry;
    carry = secondTick;
    for (int i = 0; i < `DIGIT_COUNT; i++)
    begin
      nextDigits[i] = digits[i];
      if (carry)
      begin
        if (digits[i] == digitMax)
          nextDigits[i] = '0;               // Carry ripples on
        else
        begin
          nextDigits[i] = digits[i] + 4'd1;
          carry = 1'b0;
        end
      end
    end
  end

  always_ff @(posedge OSC_50 or negedge KEY)
  begin
    if (!KEY)
    begin
      tickCount <= '0;
      digits    <= '0;
    end
    else
    begin
      tickCount <= secondTick ? '0 : tickCount + 1'b1;
      digits    <= nextDigits;
    end
  end

  assign HEX0 = segDecode(digits[0]);
  assign HEX1 = segDecode(digits[1]);
  assign HEX2 = segDecode(digits[2]);
  assign HEX3 = segDecode(digits[3]);

endmodule

// File: hw/videoPkg.sv
`include "tvBox_params.svh"

// ------------------------------
// Pixel stream types
// ------------------------------
package videoPkg;

  // One RGB pixel, red in the top bits
  typedef struct packed {
    logic [`COLOR_WIDTH-1:0] red;
    logic [`COLOR_WIDTH-1:0] green;
    logic [`COLOR_WIDTH-1:0] blue;
  } rgbPixel_t;

  // 3x3 window of set bits
  // Bits 2..0 current line, bit 0 newest pixel
  // Bits 5..3 one line above
  // Bits 8..6 two lines above
  typedef logic [8:0] markWindow_t;

  // Output colours
  localparam rgbPixel_t pixelRed   = '{red: '1, green: '0, blue: '0};
  localparam rgbPixel_t pixelWhite = '{red: '1, green: '1, blue: '1};
  localparam rgbPixel_t pixelBlack = '{red: '0, green: '0, blue: '0};

  // All nine positions set
  localparam markWindow_t windowFull = '1;

endpackage

// File: include/tvBox_params.svh
`ifndef TVBOX_PARAMS_SVH
`define TVBOX_PARAMS_SVH

// ------------------------------
// Video stream
// ------------------------------
`define COLOR_WIDTH       10          // Bits per colour channel
`define LINE_WIDTH        640         // Pixels per line, default

// ------------------------------
// Timing defaults, in OSC_50 cycles
// ------------------------------
`define TICKS_PER_SECOND  50000000    // One second at 50 MHz
`define PRESS_PERIOD      25000000    // Auto-press repeat period
`define PRESS_START       22000000    // Press begins here within period

// ------------------------------
// Seven-segment display, active low
// ------------------------------
`define DIGIT_COUNT       4           // Decimal digits on HEX0..HEX3
`define SEG_BLANK         7'b1111111  // All segments off

// Digit patterns, bit 0 is segment a
`define SEG_0             7'b1000000
`define SEG_1             7'b1111001
`define SEG_2             7'b0100100
`define SEG_3             7'b0110000
`define SEG_4             7'b0011001
`define SEG_5             7'b0010010
`define SEG_6             7'b0000010
`define SEG_7             7'b1111000
`define SEG_8             7'b0000000
`define SEG_9             7'b0010000

`endif

// File: tvBox.f
+incdir+include
hw/videoPkg.sv
hw/panelPkg.sv
hw/lumaThreshold.sv
hw/blobMarker.sv
hw/uptimeCounter.sv
hw/padAutoPress.sv
hw/tvBox.sv
verif/tvBox_assertions.sv
verif/tvBox_tb.sv

// File: verif/tvBox_assertions.sv
`timescale 1ns/1ps
`include "tvBox_params.svh"

// Port properties of the TV box top level
module tvBox_assertions
  import panelPkg::*;
(
  input logic        OSC_50,
  input logic        KEY,
  input logic        pixelValid,
  input logic        outValid,
  input sevenSeg_t   HEX4,
  input sevenSeg_t   HEX5,
  input sevenSeg_t   HEX6,
  input sevenSeg_t   HEX7,
  input padButtons_t padButtons
);

  // ------------------------------
  // Pixel strobe
  // ------------------------------
  // Luma stage plus marker stage
  validLatency: assert property (@(posedge OSC_50) disable iff (!KEY)
    outValid == $past(pixelValid, 2))
    else $error("outValid does not follow pixelValid by two cycles");

  resetQuiet: assert property (@(posedge OSC_50) !KEY |-> !outValid)
    else $error("outValid high during reset");

  // ------------------------------
  // Front panel
  // ------------------------------
  upperBlank: assert property (@(posedge OSC_50)
    HEX4 == `SEG_BLANK && HEX5 == `SEG_BLANK &&
    HEX6 == `SEG_BLANK && HEX7 == `SEG_BLANK)
    else $error("upper digits not blank");

  leftHeld: assert property (@(posedge OSC_50) padButtons.left)   // Tied high
    else $error("pad left button not high");

endmodule

bind tvBox tvBox_assertions i_assertions (
  .OSC_50     (OSC_50),
  .KEY        (KEY),
  .pixelValid (pixelValid),
  .outValid   (outValid),
  .HEX4       (HEX4),
  .HEX5       (HEX5),
  .HEX6       (HEX6),
  .HEX7       (HEX7),
  .padButtons (padButtons)
);

// File: verif/tvBox_tb.sv
`timescale 1ns/1ps
`include "tvBox_params.svh"

module tvBox_tb
  import videoPkg::*, panelPkg::*;
();

  localparam int lineWidth   = 8;
  localparam int tickCycles  = 20;   // Cycles per uptime second
  localparam int pressPeriod = 12;
  localparam int pressStart  = 9;
  localparam int resetCycles = 16;
  localparam int lastSecond  = 250;  // Uptime checked up to here
  // Twice the uptime span plus room for the pixel tests
  localparam int cycleLimit  = 2 * (resetCycles + (lastSecond + 1) * tickCycles) + 1928;

  localparam rgbPixel_t redRef   = {10'h3FF, 20'h0};
  localparam rgbPixel_t whiteRef = {30{1'b1}};
  localparam rgbPixel_t blackRef = 30'h0;
  localparam sevenSeg_t blankRef = 7'b1111111;  // All segments off

  logic        OSC_50;
  logic        KEY;
  logic [17:0] DPDT_SW;
  rgbPixel_t   pixelIn;
  logic        pixelValid;
  rgbPixel_t   pixelOut;
  logic        outValid;
  sevenSeg_t   HEX0, HEX1, HEX2, HEX3, HEX4, HEX5, HEX6, HEX7;
  padButtons_t padButtons;

  int        seed = 32'h3079;
  int        cyc = 0;            // Rising edges since time 0
  int        sinceRelease = 0;   // Rising edges with KEY high
  int        thr = 0;            // Threshold now on DPDT_SW[17:8]
  int        thrList[3] = '{0, 400, 1023};
  int        redSeen = 0;
  string     testName = "reset";
  logic      captureOn = 1'b0;
  logic      setHist[$];         // One set bit per valid pixel since reset
  rgbPixel_t expQ[$];            // Expected colours, oldest first
  int        driveQ[$];          // Cycle each of them was driven
  rgbPixel_t captured[$];
  rgbPixel_t runA[$];
  rgbPixel_t gapPixels[$];

  tvBox #(
    .lineWidth      (lineWidth),
    .ticksPerSecond (tickCycles),
    .pressPeriod    (pressPeriod),
    .pressStart     (pressStart)
  ) i_dut (.*);

  initial
  begin
    OSC_50 = 1'b0;
    forever #50 OSC_50 = ~OSC_50;   // 100 ns period
  end

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic int grayRef(input rgbPixel_t p);
    return int'(p.red) / 4 + int'(p.green) / 2 + int'(p.blue) / 8;
  endfunction

  // No history before reset
  function automatic logic histAt(input int idx);
    if (idx < 0)
      return 1'b0;
    return setHist[idx];
  endfunction

  // Colour for the newest pixel from a window over three lines
  function automatic rgbPixel_t colourRef();
    int   p;
    logic full;
    p    = setHist.size() - 1;
    full = 1'b1;
    for (int r = 0; r < 3; r++)
      for (int c = 0; c < 3; c++)
        full &= histAt(p - r * lineWidth - c);
    if (full)
      return redRef;
    else if (setHist[p])
      return whiteRef;
    return blackRef;
  endfunction

  // Decimal digit pos of the uptime modulo 10000
  function automatic int digitRef(input int seconds, input int pos);
    int scaled;
    scaled = seconds % 10000;
    for (int i = 0; i < pos; i++)
      scaled = scaled / 10;
    return scaled % 10;
  endfunction

  // Active-low patterns with bit 0 as segment a
  function automatic sevenSeg_t segRef(input int digit);
    case (digit)
      0:       return 7'b1000000;
      1:       return 7'b1111001;
      2:       return 7'b0100100;
      3:       return 7'b0110000;
      4:       return 7'b0011001;
      5:       return 7'b0010010;
      6:       return 7'b0000010;
      7:       return 7'b1111000;
      8:       return 7'b0000000;
      9:       return 7'b0010000;
      default: return 7'b1111111;
    endcase
  endfunction

  function automatic padButtons_t padRef(input logic [1:0] sw, input int k);
    padButtons_t exp;
    exp.start  = sw[0];
    exp.select = sw[1];
    exp.a      = (k % pressPeriod) >= pressStart;  // Pressed late in each period
    exp.b      = ~sw[0];
    exp.left   = 1'b1;
    exp.right  = ~sw[0];
    exp.up     = 1'b0;
    exp.down   = 1'b0;
    return exp;
  endfunction

  // ------------------------------
  // Checks and stops
  // ------------------------------
  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("error: %s expected %0h actual %0h", name, expected, actual);
      $display("test failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic stopRun(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "run stopped");
  endtask

  // ------------------------------
  // Stimulus helpers
  // ------------------------------
  task automatic idleCycles(input int n);
    repeat (n)
    begin
      @(posedge OSC_50);
      #1;
    end
  endtask

  task automatic setThreshold(input int t);
    thr            = t;
    DPDT_SW[17:8]  = 10'(t);
  endtask

  // Queue the expected colour and hold the pixel for one edge
  task automatic sendPixel(input rgbPixel_t p);
    setHist.push_back(grayRef(p) > thr);
    expQ.push_back(colourRef());
    driveQ.push_back(cyc);
    pixelIn    = p;
    pixelValid = 1'b1;
    idleCycles(1);
    pixelValid = 1'b0;
  endtask

  task automatic waitDrain();
    while (expQ.size() != 0)
      idleCycles(1);
  endtask

  // Zeros through both line delays and the window
  task automatic flushWindow();
    setThreshold(1023);
    repeat (2 * lineWidth + 3)
      sendPixel(blackRef);
  endtask

  // Same pixels on each call and captured from outValid
  task automatic runStream(input logic withGaps);
    flushWindow();
    setThreshold(200);
    waitDrain();
    captured.delete();
    captureOn = 1'b1;
    foreach (gapPixels[i])
    begin
      sendPixel(gapPixels[i]);
      if (withGaps)
        idleCycles({$random(seed)} % 3);   // 0 to 2 idle cycles
    end
    waitDrain();
    captureOn = 1'b0;
  endtask

  // ------------------------------
  // Cycle counters and timeout
  // ------------------------------
  always @(posedge OSC_50)
  begin
    cyc = cyc + 1;
    if (KEY)
      sinceRelease = sinceRelease + 1;
    if (cyc >= cycleLimit)
      stopRun("timeout: run did not finish within the cycle limit");
  end

  // Pixel comparison sampled mid-cycle
  always @(negedge OSC_50)
  begin
    if (KEY && outValid)
    begin
      if (expQ.size() == 0)
        stopRun("outValid went high with no pixel expected");
      else
      begin
        checkValue($sformatf("%s latency", testName), 32'(driveQ[0] + 2), 32'(cyc));
        checkValue(testName, 32'(expQ[0]), 32'(pixelOut));
        if (captureOn)
          captured.push_back(pixelOut);
        if (pixelOut == redRef)
          redSeen = redSeen + 1;
        expQ.delete(0);
        driveQ.delete(0);
      end
    end
    else if (expQ.size() != 0 && cyc > driveQ[0] + 2)
      stopRun("a driven pixel never appeared on outValid");
  end

  // Front panel checked every cycle
  always @(negedge OSC_50)
  begin
    checkValue("uptime HEX0", 32'(segRef(digitRef(sinceRelease / tickCycles, 0))), 32'(HEX0));
    checkValue("uptime HEX1", 32'(segRef(digitRef(sinceRelease / tickCycles, 1))), 32'(HEX1));
    checkValue("uptime HEX2", 32'(segRef(digitRef(sinceRelease / tickCycles, 2))), 32'(HEX2));
    checkValue("uptime HEX3", 32'(segRef(digitRef(sinceRelease / tickCycles, 3))), 32'(HEX3));
    checkValue("blank HEX4", 32'(blankRef), 32'(HEX4));
    checkValue("blank HEX5", 32'(blankRef), 32'(HEX5));
    checkValue("blank HEX6", 32'(blankRef), 32'(HEX6));
    checkValue("blank HEX7", 32'(blankRef), 32'(HEX7));
    checkValue("pad buttons", 32'(padRef(DPDT_SW[1:0], sinceRelease)), 32'(padButtons));
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial
  begin
    KEY        = 1'b0;
    DPDT_SW    = '0;
    pixelIn    = '0;
    pixelValid = 1'b0;
    repeat (resetCycles) @(posedge OSC_50);
    #1;
    KEY = 1'b1;

    // Random pixels at three thresholds
    for (int t = 0; t < 3; t++)
    begin
      testName = $sformatf("random pixels thr %0d", thrList[t]);
      setThreshold(thrList[t]);
      repeat (3 * lineWidth)
        sendPixel(30'($random(seed)));
    end

    // Four bright lines after a clean window
    testName = "bright region";
    flushWindow();
    setThreshold(400);
    waitDrain();
    redSeen = 0;
    repeat (4 * lineWidth)
      sendPixel(whiteRef);
    waitDrain();
    // Window full from the third pixel of the third line on
    checkValue("bright region red count", 32'(2 * lineWidth - 2), 32'(redSeen));

    // Same stream with and without gaps
    repeat (3 * lineWidth)
      gapPixels.push_back(30'($random(seed)));
    testName = "stream without gaps";
    runStream(1'b0);
    runA = captured;
    testName = "stream with gaps";
    runStream(1'b1);
    checkValue("gap stream length", 32'(runA.size()), 32'(captured.size()));
    foreach (runA[i])
      checkValue("gap stream colour", 32'(runA[i]), 32'(captured[i]));

    // Switch mapping with start low then high
    testName = "pad switches";
    for (int s = 0; s < 4; s++)
    begin
      DPDT_SW[1:0] = 2'(s);
      idleCycles(pressPeriod + 2);
    end

    // Uptime runs on past the last checked second
    while (sinceRelease < (lastSecond + 1) * tickCycles)
      idleCycles(1);

    if (expQ.size() != 0)
      stopRun("pixels still pending at the end of the run");
    else
    begin
      $display("test passed");
      $finish;
    end
  end

endmodule
